// File: hdl/mem_rd_pkg.sv
// shared sizing constants for the cache memory read-request path
// request / response payload structs, opcode and arbiter state enums
package mem_rd_pkg;

    // ********************
    // sizing
    // ********************
    localparam int unsigned N_SRC   = 3;  // miss handler, uncached unit, prefetcher
    localparam int unsigned ADDR_W  = 32;
    localparam int unsigned DATA_W  = 64; // one response beat
    localparam int unsigned TAG_W   = 2;  // rolling per-source sequence tag
    localparam int unsigned SRC_W   = 2;  // enough for N_SRC
    localparam int unsigned Q_DEPTH = 4;  // entries per source queue
    localparam int unsigned QPTR_W  = $clog2(Q_DEPTH);
    localparam int unsigned QCNT_W  = $clog2(Q_DEPTH + 1); // count reaches Q_DEPTH

    // ********************
    // types
    // ********************
    typedef enum logic {
        CMD_READ_WORD = 1'b0,
        CMD_READ_LINE = 1'b1
    } mem_cmd_e;

    typedef enum logic {
        ARB_FREE = 1'b0, // grant follows priority
        ARB_HOLD = 1'b1  // grant frozen until memory accepts
    } arb_state_e;

    typedef struct packed {
        logic [SRC_W-1:0] src; // which source issued the read
        logic [TAG_W-1:0] tag;
    } mem_id_t;

    // source side request, no id yet
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        mem_cmd_e          cmd;
    } src_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        mem_cmd_e          cmd;
        mem_id_t           id;
    } mem_req_t;

    typedef struct packed {
        mem_id_t           id;   // echoed from the request
        logic [DATA_W-1:0] data;
        logic              err;
    } mem_resp_t;

endpackage

// File: hdl/mem_rd_fxarb.sv
// fixed-priority arbiter, lowest index wins
// grant is frozen while the winner waits for ready_i
module mem_rd_fxarb
    import mem_rd_pkg::*;
#(
    parameter int unsigned N = 2
) (
    input  logic         clk_i,
    input  logic         reset_i,
    input  logic [N-1:0] req_i,
    input  logic         ready_i,
    output logic [N-1:0] gnt_o
);

    arb_state_e   state_q;
    logic [N-1:0] gnt_q;   // winner saved on entry to hold
    logic [N-1:0] pri_gnt; // combinational priority pick
    logic         found;

    // lowest-index one-hot pick
    always_comb begin
        pri_gnt = '0;
        found   = 1'b0;
        for (int i = 0; i < N; i++) begin
            if (req_i[i] && !found) begin
                pri_gnt[i] = 1'b1;
                found      = 1'b1;
            end
        end
    end

    assign gnt_o = (state_q == ARB_HOLD) ? gnt_q : pri_gnt; // no added latency when free

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ARB_FREE;
            gnt_q   <= '0;
        end else begin
            case (state_q)
                ARB_FREE: begin
                    if (found && !ready_i) begin // winner stalled, lock it
                        state_q <= ARB_HOLD;
                        gnt_q   <= pri_gnt;
                    end
                end
                ARB_HOLD: begin
                    if (ready_i) state_q <= ARB_FREE; // transfer this cycle
                end
                default: state_q <= ARB_FREE;
            endcase
        end
    end

    a_gnt_onehot0: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(gnt_o));

endmodule

// File: hdl/mem_rd_req_queue.sv
// per-source request queue, circular buffer of Q_DEPTH entries
// stamps each accepted command with source id and rolling tag
module mem_rd_req_queue
    import mem_rd_pkg::*;
#(
    parameter int unsigned SRC_ID = 0 // placed in id.src, below N_SRC
) (
    input  logic     clk_i,
    input  logic     reset_i,
    // source side
    input  logic     src_valid_i,
    input  src_req_t src_req_i,
    output logic     src_ready_o,
    // arbiter side
    output logic     q_valid_o,
    output mem_req_t q_req_o,
    input  logic     q_ready_i
);

    mem_req_t          buf_q [Q_DEPTH]; // payload storage
    logic [QPTR_W-1:0] wr_ptr_q;
    logic [QPTR_W-1:0] rd_ptr_q;
    logic [QCNT_W-1:0] count_q;
    logic [TAG_W-1:0]  tag_q;           // tag for the next accepted request
    logic              push;
    logic              pop;
    mem_req_t          new_req;

    assign src_ready_o = (count_q != QCNT_W'(Q_DEPTH)); // room left
    assign q_valid_o   = (count_q != '0);
    assign q_req_o     = buf_q[rd_ptr_q];               // oldest entry

    assign push = src_valid_i & src_ready_o;
    assign pop  = q_valid_o & q_ready_i;

    // build the memory request at accept time
    always_comb begin
        new_req        = '0;
        new_req.addr   = src_req_i.addr;
        new_req.cmd    = src_req_i.cmd;
        new_req.id.src = SRC_W'(SRC_ID);
        new_req.id.tag = tag_q;
    end

    // ********************
    // storage, no reset
    // ********************
    always_ff @(posedge clk_i) begin
        if (push) buf_q[wr_ptr_q] <= new_req;
    end

    // ********************
    // pointers and count
    // ********************
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            tag_q    <= '0; // first tag after reset is 0
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == QPTR_W'(Q_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
                tag_q    <= tag_q + 1'b1; // wraps naturally
            end
            if (pop) rd_ptr_q <= (rd_ptr_q == QPTR_W'(Q_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // idle or push+pop
            endcase
        end
    end

    a_count_max: assert property (@(posedge clk_i) disable iff (reset_i)
        count_q <= QCNT_W'(Q_DEPTH));

endmodule

// File: hdl/mem_req_read_arbiter.sv
// memory read channel arbiter over N request queues
// fixed-priority grant, one-hot and-or payload select, ready back to winner
module mem_req_read_arbiter
    import mem_rd_pkg::*;
#(
    parameter int unsigned N = 2
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    // queue side
    input  logic     [N-1:0]      mem_req_read_valid_i,
    input  mem_req_t [N-1:0]      mem_req_read_i,
    output logic     [N-1:0]      mem_req_read_ready_o,
    // memory side
    output logic                  mem_req_read_valid_o,
    output mem_req_t              mem_req_read_o,
    input  logic                  mem_req_read_ready_i
);

    logic [N-1:0]                 gnt;
    logic [$bits(mem_req_t)-1:0]  sel_req; // and-or accumulator

    mem_rd_fxarb #(
        .N       (N)
    ) i_mem_rd_fxarb (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (mem_req_read_valid_i),
        .ready_i (mem_req_read_ready_i),
        .gnt_o   (gnt)
    );

    assign mem_req_read_valid_o = |(gnt & mem_req_read_valid_i);

    // one-hot mux, grant masks every input
    always_comb begin
        sel_req = '0;
        for (int i = 0; i < N; i++) begin
            sel_req = sel_req | ({$bits(mem_req_t){gnt[i]}} & mem_req_read_i[i]);
        end
    end

    assign mem_req_read_o = mem_req_t'(sel_req);

    // only the granted, valid queue sees ready
    assign mem_req_read_ready_o = {N{mem_req_read_ready_i}} & gnt & mem_req_read_valid_i;

    // payload must not move while memory stalls, even if a higher source wakes up
    a_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        mem_req_read_valid_o && !mem_req_read_ready_i |=> $stable(mem_req_read_o));

endmodule

// File: hdl/mem_rd_resp_router.sv
// memory response router, steers by id.src
// ready comes back from the addressed source only
module mem_rd_resp_router
    import mem_rd_pkg::*;
(
    input  logic                        clk_i,   // assertion only
    input  logic                        reset_i, // assertion only
    // memory side
    input  logic                        mem_resp_valid_i,
    input  mem_resp_t                   mem_resp_i,
    output logic                        mem_resp_ready_o,
    // source side
    output logic      [N_SRC-1:0]       src_resp_valid_o,
    output mem_resp_t [N_SRC-1:0]       src_resp_o,
    input  logic      [N_SRC-1:0]       src_resp_ready_i
);

    logic [N_SRC-1:0] dst_oh; // decoded destination

    always_comb begin
        dst_oh = '0;
        for (int i = 0; i < N_SRC; i++) begin
            if (mem_resp_i.id.src == SRC_W'(i)) dst_oh[i] = 1'b1;
        end
    end

    // fan out the payload, valid only at the destination
    for (genvar k = 0; k < N_SRC; k++) begin : g_fanout
        assign src_resp_o[k] = mem_resp_i;
    end

    assign src_resp_valid_o = {N_SRC{mem_resp_valid_i}} & dst_oh;
    assign mem_resp_ready_o = |(dst_oh & src_resp_ready_i); // zero if src out of range

    // memory must echo a source id that was issued
    a_src_range: assert property (@(posedge clk_i) disable iff (reset_i)
        mem_resp_valid_i |-> (mem_resp_i.id.src < SRC_W'(N_SRC)));

endmodule

// File: hdl/mem_rd_top.sv
// top of the cache memory read-request path
// three source queues, read arbiter, response router
module mem_rd_top
    import mem_rd_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   reset_i,
    // source request channels
    input  logic      [N_SRC-1:0]  src_req_valid_i,
    input  src_req_t  [N_SRC-1:0]  src_req_i,
    output logic      [N_SRC-1:0]  src_req_ready_o,
    // memory request channel
    output logic                   mem_req_valid_o,
    output mem_req_t               mem_req_o,
    input  logic                   mem_req_ready_i,
    // memory response channel
    input  logic                   mem_resp_valid_i,
    input  mem_resp_t              mem_resp_i,
    output logic                   mem_resp_ready_o,
    // source response channels
    output logic      [N_SRC-1:0]  src_resp_valid_o,
    output mem_resp_t [N_SRC-1:0]  src_resp_o,
    input  logic      [N_SRC-1:0]  src_resp_ready_i
);

    // queue to arbiter
    logic     [N_SRC-1:0] q_valid;
    mem_req_t [N_SRC-1:0] q_req;
    logic     [N_SRC-1:0] q_ready;

    // ********************
    // request path
    // ********************
    for (genvar k = 0; k < N_SRC; k++) begin : g_queue
        mem_rd_req_queue #(
            .SRC_ID      (k) // source number into id.src
        ) i_mem_rd_req_queue (
            .clk_i       (clk_i),
            .reset_i     (reset_i),
            .src_valid_i (src_req_valid_i[k]),
            .src_req_i   (src_req_i[k]),
            .src_ready_o (src_req_ready_o[k]),
            .q_valid_o   (q_valid[k]),
            .q_req_o     (q_req[k]),
            .q_ready_i   (q_ready[k])
        );
    end

    mem_req_read_arbiter #(
        .N                    (N_SRC)
    ) i_mem_req_read_arbiter (
        .clk_i                (clk_i),
        .reset_i              (reset_i),
        .mem_req_read_valid_i (q_valid),
        .mem_req_read_i       (q_req),
        .mem_req_read_ready_o (q_ready),
        .mem_req_read_valid_o (mem_req_valid_o),
        .mem_req_read_o       (mem_req_o),
        .mem_req_read_ready_i (mem_req_ready_i)
    );

    // ********************
    // response path
    // ********************
    mem_rd_resp_router i_mem_rd_resp_router (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_i       (mem_resp_i),
        .mem_resp_ready_o (mem_resp_ready_o),
        .src_resp_valid_o (src_resp_valid_o),
        .src_resp_o       (src_resp_o),
        .src_resp_ready_i (src_resp_ready_i)
    );

endmodule

// File: verif/tb_mem_rd_top.sv
// testbench for the cache memory read-request path
// clock, reset, compare tasks, directed tests for priority, hold, queue, routing
module tb_mem_rd_top
    import mem_rd_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 50; // cycles per wait loop

    logic                   clk_i;
    logic                   reset_i;
    logic      [N_SRC-1:0]  src_req_valid_i;
    src_req_t  [N_SRC-1:0]  src_req_i;
    logic      [N_SRC-1:0]  src_req_ready_o;
    logic                   mem_req_valid_o;
    mem_req_t               mem_req_o;
    logic                   mem_req_ready_i;
    logic                   mem_resp_valid_i;
    mem_resp_t              mem_resp_i;
    logic                   mem_resp_ready_o;
    logic      [N_SRC-1:0]  src_resp_valid_o;
    mem_resp_t [N_SRC-1:0]  src_resp_o;
    logic      [N_SRC-1:0]  src_resp_ready_i;
    int                     check_errors   = 0;
    int                     timeout_errors = 0;

    mem_rd_top i_mem_rd_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i; // 8 ns period
    end

    // ********************
    // compare tasks
    // ********************
    task automatic check_mem_req(input string name, input mem_req_t exp, input mem_req_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            check_errors++;
        end
    endtask

    task automatic check_src_resp(input string name, input mem_resp_t exp, input mem_resp_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            check_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
            check_errors++;
        end
    endtask

    // ********************
    // stimulus helpers
    // ********************
    function automatic src_req_t rand_req();
        src_req_t r;
        r.addr = $urandom;
        r.cmd  = ($urandom & 1) ? CMD_READ_LINE : CMD_READ_WORD;
        return r;
    endfunction

    // what memory should see: payload plus source number and tag
    function automatic mem_req_t expected_req(input src_req_t r, input int src, input int tag);
        mem_req_t e;
        e.addr   = r.addr;
        e.cmd    = r.cmd;
        e.id.src = SRC_W'(src);
        e.id.tag = TAG_W'(tag);
        return e;
    endfunction

    task automatic reset_dut();
        @(posedge clk_i);
        reset_i          <= 1'b1;
        src_req_valid_i  <= '0;
        src_req_i        <= '0;
        mem_req_ready_i  <= 1'b0;
        mem_resp_valid_i <= 1'b0;
        mem_resp_i       <= '0;
        src_resp_ready_i <= '1;
        repeat (2) @(posedge clk_i); // 2 reset cycles
        reset_i <= 1'b0;
        @(negedge clk_i);
        check_flag("mem_req_valid_o", 1'b0, mem_req_valid_o);
        for (int k = 0; k < N_SRC; k++) begin
            check_flag($sformatf("src_req_ready_o[%0d]", k), 1'b1, src_req_ready_o[k]);
            check_flag($sformatf("src_resp_valid_o[%0d]", k), 1'b0, src_resp_valid_o[k]);
        end
    endtask

    // valid already up, wait for every masked queue to take it
    task automatic hold_until_accepted(input logic [N_SRC-1:0] mask);
        int n;
        n = 0;
        @(negedge clk_i);
        while ((src_req_ready_o & mask) != mask && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if ((src_req_ready_o & mask) != mask) begin
            $display("timeout: source queue never accepted request, mask %b", mask);
            timeout_errors++;
        end
        @(posedge clk_i); // handshake edge
        src_req_valid_i <= src_req_valid_i & ~mask;
    endtask

    task automatic send_reqs(input logic [N_SRC-1:0] mask, input src_req_t [N_SRC-1:0] reqs);
        @(posedge clk_i);
        src_req_valid_i <= mask;
        src_req_i       <= reqs;
        hold_until_accepted(mask);
    endtask

    task automatic send_one(input int src, input src_req_t r);
        logic     [N_SRC-1:0] mask;
        src_req_t [N_SRC-1:0] reqs;
        mask      = '0;
        mask[src] = 1'b1;
        reqs      = '0;
        reqs[src] = r;
        send_reqs(mask, reqs);
    endtask

    // wait for a memory handshake and compare what moved
    task automatic expect_transfer(input mem_req_t exp);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!(mem_req_valid_o && mem_req_ready_i) && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (!(mem_req_valid_o && mem_req_ready_i)) begin
            $display("timeout: expected memory request with addr %h never transferred", exp.addr);
            timeout_errors++;
        end else begin
            check_mem_req("mem_req_o", exp, mem_req_o);
        end
        @(posedge clk_i); // transfer edge
    endtask

    task automatic wait_mem_valid();
        int n;
        n = 0;
        @(negedge clk_i);
        while (!mem_req_valid_o && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (!mem_req_valid_o) begin
            $display("timeout: memory request valid never rose");
            timeout_errors++;
        end
    endtask

    // ********************
    // directed tests
    // ********************
    task automatic test_single_request();
        src_req_t r;
        reset_dut();
        r = rand_req();
        @(posedge clk_i);
        mem_req_ready_i <= 1'b1;
        send_one(1, r);
        expect_transfer(expected_req(r, 1, 0));
    endtask

    task automatic test_fixed_priority();
        src_req_t [N_SRC-1:0] reqs;
        reset_dut();
        reqs    = '0;
        reqs[0] = rand_req();
        reqs[2] = rand_req();
        send_reqs(3'b101, reqs); // same cycle, memory stalled
        mem_req_ready_i <= 1'b1;
        expect_transfer(expected_req(reqs[0], 0, 0)); // source 0 first
        expect_transfer(expected_req(reqs[2], 2, 0));
    endtask

    task automatic test_grant_hold();
        src_req_t r0;
        src_req_t r2;
        reset_dut();
        r0 = rand_req();
        r2 = rand_req();
        send_one(2, r2);
        wait_mem_valid();
        check_mem_req("mem_req_o", expected_req(r2, 2, 0), mem_req_o);
        send_one(0, r0); // higher priority shows up late
        repeat (3) begin
            @(negedge clk_i);
            check_mem_req("mem_req_o", expected_req(r2, 2, 0), mem_req_o); // still source 2
        end
        @(posedge clk_i);
        mem_req_ready_i <= 1'b1;
        expect_transfer(expected_req(r2, 2, 0));
        expect_transfer(expected_req(r0, 0, 0));
    endtask

    task automatic test_queue_order();
        src_req_t burst [5];
        reset_dut();
        foreach (burst[i]) burst[i] = rand_req();
        for (int i = 0; i < 4; i++) send_one(1, burst[i]); // fills the queue
        @(posedge clk_i);
        src_req_valid_i[1] <= 1'b1; // fifth offer, no room
        src_req_i[1]       <= burst[4];
        repeat (3) begin
            @(negedge clk_i);
            check_flag("src_req_ready_o[1]", 1'b0, src_req_ready_o[1]);
        end
        @(posedge clk_i);
        mem_req_ready_i <= 1'b1;
        expect_transfer(expected_req(burst[0], 1, 0));
        mem_req_ready_i <= 1'b0; // freeze drain, let the fifth in
        hold_until_accepted(3'b010);
        mem_req_ready_i <= 1'b1;
        for (int i = 1; i < 4; i++) expect_transfer(expected_req(burst[i], 1, i));
        expect_transfer(expected_req(burst[4], 1, 0)); // tag wrapped
    endtask

    task automatic test_resp_routing();
        mem_resp_t resp;
        reset_dut();
        for (int k = 0; k < N_SRC; k++) begin
            resp.id.src = SRC_W'(k);
            resp.id.tag = TAG_W'($urandom);
            resp.data   = {$urandom, $urandom};
            resp.err    = 1'($urandom);
            @(posedge clk_i);
            mem_resp_valid_i    <= 1'b1;
            mem_resp_i          <= resp;
            src_resp_ready_i    <= '0;
            src_resp_ready_i[k] <= 1'b1; // only the addressed source ready
            @(negedge clk_i); // zero-cycle path
            for (int j = 0; j < N_SRC; j++) begin
                check_flag($sformatf("src_resp_valid_o[%0d]", j), (j == k), src_resp_valid_o[j]);
            end
            check_src_resp($sformatf("src_resp_o[%0d]", k), resp, src_resp_o[k]);
            check_flag("mem_resp_ready_o", 1'b1, mem_resp_ready_o);
            @(posedge clk_i);
            src_resp_ready_i    <= '1;
            src_resp_ready_i[k] <= 1'b0; // addressed source stalls
            @(negedge clk_i);
            check_flag("mem_resp_ready_o", 1'b0, mem_resp_ready_o);
            @(posedge clk_i);
            mem_resp_valid_i <= 1'b0;
            src_resp_ready_i <= '1;
        end
    endtask

    initial begin
        void'($urandom(68));
        reset_i          <= 1'b1;
        src_req_valid_i  <= '0;
        src_req_i        <= '0;
        mem_req_ready_i  <= 1'b0;
        mem_resp_valid_i <= 1'b0;
        mem_resp_i       <= '0;
        src_resp_ready_i <= '1;
        test_single_request();
        test_fixed_priority();
        test_grant_hold();
        test_queue_order();
        test_resp_routing();
        $display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: mem_rd_top.f
hdl/mem_rd_pkg.sv
hdl/mem_rd_fxarb.sv
hdl/mem_rd_req_queue.sv
hdl/mem_req_read_arbiter.sv
hdl/mem_rd_resp_router.sv
hdl/mem_rd_top.sv
verif/tb_mem_rd_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mem_rd_top -f mem_rd_top.f \
    && ./obj_dir/Vtb_mem_rd_top > sim.log \
    || { echo "build or run failed"; exit 1; }
cat sim.log
grep -q "^RESULT: PASS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
